//--- Makefile
# Verilator build and run of the byte port testbench

SRCS := $(wildcard design/*.sv dv/*.sv)

obj_dir/Vvuart_tb: files.f $(SRCS)
	verilator --binary --assert --timescale 1ns/1ps --top-module vuart_tb -f files.f

run: obj_dir/Vvuart_tb
	@out="$$(./obj_dir/Vvuart_tb)"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir

.PHONY: run clean

//--- design/byte_fifo.sv
// Synchronous byte FIFO between the register block and the serializer.
// Head entry is shown on rdata without a read delay; a push while full
// is dropped, a pop while empty is ignored.

`default_nettype none

module byte_fifo import vuart_pkg::*; (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        push,
    input  wire [7:0]  wdata,
    input  wire        pop,
    output logic [7:0] rdata,
    output logic       full,
    output logic       empty
);

    // Storage, no reset needed on the data itself
    logic [7:0]       mem [FIFO_DEPTH];

    // One extra bit tells a full FIFO from an empty one
    logic [FIFO_AW:0] wr_ptr;
    logic [FIFO_AW:0] rd_ptr;
    logic             push_ok;
    logic             pop_ok;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
                   (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);

    assign push_ok = push && !full;
    assign pop_ok  = pop && !empty;

    // Head of queue, combinational
    assign rdata = mem[rd_ptr[FIFO_AW-1:0]];

    // ----------------------------------------
    // Pointers
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            // Push and pop in one cycle are both served
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Data write
    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr[FIFO_AW-1:0]] <= wdata;
        end
    end

endmodule

`default_nettype wire

//--- design/uart_tx_serial.sv
// 8N1 serializer. Pops a byte from the FIFO while idle and sends
// start bit, eight data bits LSB first and stop bit on txd, each
// bit CLKS_PER_BIT cycles long.

`default_nettype none

module uart_tx_serial import vuart_pkg::*; (
    input  wire       clk,
    input  wire       rst_n,
    input  wire       fifo_empty,
    input  wire [7:0] fifo_rdata,
    output logic      fifo_pop,
    output logic      txd,
    output logic      tx_busy
);

    tx_state_t            state;
    logic [BIT_CNT_W-1:0] bit_cnt;
    logic [2:0]           bit_idx;
    logic [7:0]           shift_q;
    logic                 bit_end;

    // Last cycle of the current bit period
    assign bit_end  = (bit_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1));

    // Pop in the idle cycle, same edge as the byte is latched
    assign fifo_pop = (state == TX_IDLE) && !fifo_empty;
    assign tx_busy  = (state != TX_IDLE);

    // ----------------------------------------
    // Frame FSM
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= TX_IDLE;
            bit_cnt <= '0;
            bit_idx <= '0;
            txd     <= 1'b1;
        end else begin
            if (state != TX_IDLE) begin
                bit_cnt <= bit_end ? '0 : bit_cnt + 1'b1;
            end
            case (state)
                TX_IDLE: begin
                    bit_cnt <= '0;
                    bit_idx <= '0;
                    if (!fifo_empty) begin
                        // Start bit goes out from the next cycle
                        txd   <= 1'b0;
                        state <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        txd   <= shift_q[0];
                        state <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            txd   <= 1'b1;
                            state <= TX_STOP;
                        end else begin
                            txd     <= shift_q[1];
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_end) begin
                        state <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Shift register, loaded on pop and moved at each data bit end
    always_ff @(posedge clk) begin
        if (fifo_pop) begin
            shift_q <= fifo_rdata;
        end else if (state == TX_DATA && bit_end) begin
            shift_q <= {1'b0, shift_q[7:1]};
        end
    end

endmodule

`default_nettype wire

//--- design/vuart_pkg.sv
// Shared constants and types for the memory-mapped byte port.
// Modules pull these in with a wildcard import in their header.

`default_nettype none

package vuart_pkg;

    // ----------------------------------------
    // Address map
    // ----------------------------------------
    // Upper address byte that selects this block
    localparam logic [7:0]  BASE_ADDR     = 8'h02;

    // Register offsets, bits 3 to 0 of the byte address
    localparam logic [3:0]  UART_TX_REG   = 4'h0;
    localparam logic [3:0]  UART_STAT_REG = 4'h4;
    localparam logic [3:0]  UART_RX_REG   = 4'h8;

    // Returned by a receive read with nothing waiting
    localparam logic [31:0] RX_EMPTY_WORD = 32'hFFFF_FF00;

    // ----------------------------------------
    // Sizes and serial timing
    // ----------------------------------------
    localparam int FIFO_DEPTH   = 8;
    localparam int FIFO_AW      = 3;
    localparam int CLKS_PER_BIT = 4;
    // Width of the bit-period counter
    localparam int BIT_CNT_W    = $clog2(CLKS_PER_BIT);

    // Decoded bus request
    typedef enum logic [1:0] {
        OP_NONE,
        OP_TX_WRITE,
        OP_STAT_READ,
        OP_RX_READ
    } bus_op_t;

    // Serializer states
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

endpackage

`default_nettype wire

//--- design/vuart_regs.sv
// Bus register block on the native memory bus.
// Decodes transmit, status and receive accesses, stalls transmit
// writes while the FIFO is full and answers with one-cycle mem_ready.

`default_nettype none

module vuart_regs import vuart_pkg::*; (
    input  wire        clk,
    input  wire        rst_n,
    // CPU side
    input  wire        mem_valid,
    input  wire [31:0] mem_addr,
    input  wire [31:0] mem_wdata,
    input  wire [3:0]  mem_wstrb,
    output logic       mem_ready,
    output logic [31:0] mem_rdata,
    // Receive byte stream
    input  wire        rx_valid,
    input  wire [7:0]  rx_data,
    output logic       rx_ready,
    // Transmit FIFO and serializer
    input  wire        fifo_full,
    input  wire        fifo_empty,
    input  wire        tx_busy,
    output logic       fifo_push,
    output logic [7:0] fifo_wdata
);

    // ----------------------------------------
    // Request detection
    // ----------------------------------------
    logic       mem_valid_q;
    logic       stalled;
    logic       new_req;
    logic       take;
    logic       is_read;
    logic [3:0] offset;
    bus_op_t    op;

    assign offset  = mem_addr[3:0];
    assign is_read = (mem_wstrb == 4'b0000);

    // New request only on the rising edge of mem_valid
    assign new_req = mem_valid && !mem_valid_q && (mem_addr[31:24] == BASE_ADDR);
    // A stalled write is retried every cycle
    assign take    = new_req || stalled;

    always_comb begin
        op = OP_NONE;
        if (take) begin
            if (!is_read) begin
                // Only lane 0 of the transmit register starts a byte
                if (offset == UART_TX_REG && mem_wstrb[0]) begin
                    op = OP_TX_WRITE;
                end
            end else begin
                case (offset)
                    UART_STAT_REG: op = OP_STAT_READ;
                    UART_RX_REG:   op = OP_RX_READ;
                    default:       op = OP_NONE;
                endcase
            end
        end
    end

    // ----------------------------------------
    // Control pulses and stall flag
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_valid_q <= 1'b0;
            stalled     <= 1'b0;
            mem_ready   <= 1'b0;
            rx_ready    <= 1'b0;
            fifo_push   <= 1'b0;
        end else begin
            // Single-cycle pulses by default
            mem_ready   <= 1'b0;
            rx_ready    <= 1'b0;
            fifo_push   <= 1'b0;
            mem_valid_q <= mem_valid;
            case (op)
                OP_TX_WRITE: begin
                    if (fifo_full) begin
                        // Hold off the CPU until a slot frees up
                        stalled <= 1'b1;
                    end else begin
                        stalled   <= 1'b0;
                        fifo_push <= 1'b1;
                        mem_ready <= 1'b1;
                    end
                end
                OP_STAT_READ: mem_ready <= 1'b1;
                OP_RX_READ: begin
                    mem_ready <= 1'b1;
                    rx_ready  <= rx_valid;
                end
                default: begin
                    // Reads of unmapped offsets still complete, writes do not
                    mem_ready <= take && is_read;
                end
            endcase
        end
    end

    // ----------------------------------------
    // Read data and write byte
    // ----------------------------------------
    always_ff @(posedge clk) begin
        mem_rdata <= '0;
        if (op == OP_TX_WRITE) begin
            fifo_wdata <= mem_wdata[7:0];
        end
        if (op == OP_STAT_READ) begin
            mem_rdata <= {29'd0, tx_busy || !fifo_empty, rx_valid, fifo_full};
        end
        if (op == OP_RX_READ) begin
            // Zero-extended byte, or the empty marker
            mem_rdata <= rx_valid ? {24'd0, rx_data} : RX_EMPTY_WORD;
        end
    end

endmodule

`default_nettype wire

//--- design/vuart_top.sv
// Top level of the byte port: register block feeding the transmit
// FIFO, which in turn feeds the 8N1 serializer driving txd.
// The receive side passes straight to the register block as a stream.

`default_nettype none

module vuart_top (
    input  wire        clk,
    input  wire        rst_n,
    // Native memory bus
    input  wire        mem_valid,
    input  wire [31:0] mem_addr,
    input  wire [31:0] mem_wdata,
    input  wire [3:0]  mem_wstrb,
    output wire        mem_ready,
    output wire [31:0] mem_rdata,
    // Receive byte stream
    input  wire        rx_valid,
    input  wire [7:0]  rx_data,
    output wire        rx_ready,
    // Serial output
    output wire        txd
);

    // ----------------------------------------
    // Internal links
    // ----------------------------------------
    wire       fifo_push;
    wire [7:0] fifo_wdata;
    wire       fifo_full;
    wire       fifo_empty;
    wire [7:0] fifo_rdata;
    wire       fifo_pop;
    wire       tx_busy;

    // Producer
    vuart_regs u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .mem_valid  (mem_valid),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_wstrb  (mem_wstrb),
        .mem_ready  (mem_ready),
        .mem_rdata  (mem_rdata),
        .rx_valid   (rx_valid),
        .rx_data    (rx_data),
        .rx_ready   (rx_ready),
        .fifo_full  (fifo_full),
        .fifo_empty (fifo_empty),
        .tx_busy    (tx_busy),
        .fifo_push  (fifo_push),
        .fifo_wdata (fifo_wdata)
    );

    // Buffer
    byte_fifo u_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (fifo_push),
        .wdata (fifo_wdata),
        .pop   (fifo_pop),
        .rdata (fifo_rdata),
        .full  (fifo_full),
        .empty (fifo_empty)
    );

    // Consumer
    uart_tx_serial u_tx (
        .clk        (clk),
        .rst_n      (rst_n),
        .fifo_empty (fifo_empty),
        .fifo_rdata (fifo_rdata),
        .fifo_pop   (fifo_pop),
        .txd        (txd),
        .tx_busy    (tx_busy)
    );

endmodule

`default_nettype wire

//--- dv/vuart_chk.sv
// Bound checker for the byte port. Concurrent assertions on the bus
// pulse, the receive stream, FIFO pushes and the idle line level.

`default_nettype none

module vuart_chk import vuart_pkg::*; (
    input wire       clk,
    input wire       rst_n,
    input wire       mem_ready,
    input wire       rx_valid,
    input wire       rx_ready,
    input wire       fifo_push,
    input wire       fifo_full,
    input wire       txd,
    input wire [1:0] tx_state
);
    timeunit 1ns;
    timeprecision 1ps;

    // mem_ready is a single-cycle pulse
    a_ready_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        mem_ready |=> !mem_ready)
        else $error("mem_ready high for two cycles in a row");

    // Byte consumed only while one is offered
    a_rx_ready: assert property (@(posedge clk) disable iff (!rst_n)
        rx_ready |-> rx_valid)
        else $error("rx_ready high without rx_valid");

    // No push into a full FIFO
    a_no_full_push: assert property (@(posedge clk) disable iff (!rst_n)
        !(fifo_push && fifo_full))
        else $error("fifo_push while fifo_full");

    a_idle_line: assert property (@(posedge clk) disable iff (!rst_n)
        (tx_state == TX_IDLE) |-> txd)
        else $error("txd low while the serializer is idle");

endmodule

bind vuart_top vuart_chk u_chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .mem_ready (mem_ready),
    .rx_valid  (rx_valid),
    .rx_ready  (rx_ready),
    .fifo_push (fifo_push),
    .fifo_full (fifo_full),
    .txd       (txd),
    .tx_state  (u_tx.state)
);

`default_nettype wire

//--- dv/vuart_tb.sv
// Directed testbench for the byte port. Drives the native bus on the
// falling clock edge, decodes txd back into bytes and checks transmit,
// receive, status and ignored requests against the register rules.

`default_nettype none

module vuart_tb import vuart_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 20;
    localparam int FRAME_CLKS = 10 * CLKS_PER_BIT;
    // Longest stall is about one frame
    localparam int BUS_LIMIT  = 2 * FRAME_CLKS + 10;
    // Bytes sent by the single, burst and status tests
    localparam int TX_BYTES    = 1 + 12 + FIFO_DEPTH + 1;
    localparam int WATCHDOG_NS = TX_BYTES * FRAME_CLKS * CLK_PERIOD + 20000;
    localparam logic [31:0] TX_ADDR   = {BASE_ADDR, 20'h0, UART_TX_REG};
    localparam logic [31:0] STAT_ADDR = {BASE_ADDR, 20'h0, UART_STAT_REG};
    localparam logic [31:0] RX_ADDR   = {BASE_ADDR, 20'h0, UART_RX_REG};

    logic        clk;
    logic        rst_n;
    logic        mem_valid;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [3:0]  mem_wstrb;
    wire         mem_ready;
    wire  [31:0] mem_rdata;
    logic        rx_valid;
    logic [7:0]  rx_data;
    wire         rx_ready;
    wire         txd;

    int          err_cnt;
    int          frame_errs;
    int          test_err_start;
    int          tests_run;
    int          tests_failed;
    int          rx_pulses;
    string       cur_test;
    logic [31:0] rng_state;
    // Bytes recovered from txd, oldest first
    logic [7:0]  line_bytes[$];

    vuart_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_valid (mem_valid),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_wstrb (mem_wstrb),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata),
        .rx_valid  (rx_valid),
        .rx_data   (rx_data),
        .rx_ready  (rx_ready),
        .txd       (txd)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic int total_errs();
        return err_cnt + frame_errs;
    endfunction

    task automatic check_word(input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else begin
            $display("ERR %s: expected %h, got %h", cur_test, exp, got);
            err_cnt++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("%s: %s", cur_test, what);
            err_cnt++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        test_err_start = total_errs();
    endtask

    task automatic finish_test();
        tests_run++;
        if (total_errs() == test_err_start) begin
            $display("[%s] passed", cur_test);
        end else begin
            $display("[%s] failed with %0d errors", cur_test, total_errs() - test_err_start);
            tests_failed++;
        end
    endtask

    // Hold mem_valid until mem_ready, then drop it for one cycle
    task automatic bus_access(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, output logic [31:0] rdata,
                              output int cycles);
        cycles    = 0;
        rdata     = '0;
        mem_addr  = addr;
        mem_wdata = data;
        mem_wstrb = strb;
        mem_valid = 1'b1;
        do begin
            @(negedge clk);
            cycles++;
        end while (mem_ready !== 1'b1 && cycles < BUS_LIMIT);
        rdata = mem_rdata;
        check_true(mem_ready === 1'b1, "bus access got no mem_ready within the cycle limit");
        mem_valid = 1'b0;
        @(negedge clk);
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, output int cycles);
        logic [31:0] unused;
        bus_access(addr, data, strb, unused, cycles);
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
        int cycles;
        bus_access(addr, 32'h0, 4'b0000, data, cycles);
    endtask

    task automatic wait_for_bytes(input int n);
        int waited;
        waited = 0;
        while (line_bytes.size() < n && waited < n * (FRAME_CLKS + 2) + FRAME_CLKS) begin
            @(negedge clk);
            waited++;
        end
        check_true(line_bytes.size() >= n, "expected frames did not appear on txd in time");
    endtask

    // Compare recovered bytes with the write order
    task automatic check_line(input logic [7:0] exp_q[$]);
        logic [7:0] got;
        foreach (exp_q[i]) begin
            got = (line_bytes.size() > 0) ? line_bytes.pop_front() : 8'hxx;
            check_word({24'd0, exp_q[i]}, {24'd0, got});
        end
    endtask

    // Serial line must stay high with nothing decoded
    task automatic watch_idle_line(input int n);
        int low;
        low = 0;
        repeat (n) begin
            @(negedge clk);
            if (txd !== 1'b1) low++;
        end
        check_true(low == 0 && line_bytes.size() == 0, "a frame appeared on txd");
    endtask

    // ----------------------------------------
    // Serial decoder and receive monitor
    // ----------------------------------------
    initial begin : line_decoder
        logic [7:0] rx_byte;
        forever begin
            @(negedge clk);
            if (rst_n === 1'b1 && txd === 1'b0) begin
                // Middle of the start bit
                repeat (CLKS_PER_BIT / 2) @(negedge clk);
                assert (txd === 1'b0) else begin
                    $display("Start bit on txd ended early");
                    frame_errs++;
                end
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS_PER_BIT) @(negedge clk);
                    rx_byte[i] = txd;
                end
                repeat (CLKS_PER_BIT) @(negedge clk);
                assert (txd === 1'b1) else begin
                    $display("Stop bit missing after byte %h", rx_byte);
                    frame_errs++;
                end
                line_bytes.push_back(rx_byte);
            end
        end
    end

    always @(negedge clk) begin
        if (rx_ready === 1'b1) rx_pulses++;
    end

    // ----------------------------------------
    // Tests
    // ----------------------------------------
    task automatic test_single_tx();
        logic [31:0] r;
        logic [7:0]  exp_q[$];
        int          cyc;
        start_test("single_tx");
        r = next_rand();
        exp_q.push_back(r[7:0]);
        bus_write(TX_ADDR, r, 4'b0001, cyc);
        wait_for_bytes(1);
        check_line(exp_q);
        finish_test();
    endtask

    task automatic test_burst_tx();
        logic [31:0] r;
        logic [7:0]  exp_q[$];
        int          cyc;
        int          stalls;
        start_test("burst_tx");
        stalls = 0;
        for (int i = 0; i < 12; i++) begin
            r = next_rand();
            exp_q.push_back(r[7:0]);
            bus_write(TX_ADDR, r, 4'b1111, cyc);
            if (cyc > 1) stalls++;
        end
        check_true(stalls > 0, "no transmit write stalled on a full FIFO");
        wait_for_bytes(12);
        check_line(exp_q);
        finish_test();
    endtask

    task automatic test_rx_read();
        logic [31:0] r;
        logic [31:0] got;
        int          pulses_before;
        start_test("rx_read");
        r = next_rand();
        rx_data  = r[7:0];
        rx_valid = 1'b1;
        pulses_before = rx_pulses;
        bus_read(RX_ADDR, got);
        check_word({24'd0, r[7:0]}, got);
        check_true(rx_pulses - pulses_before == 1, "rx_ready was not seen high exactly once");
        // Dropped only after rx_ready has gone low again
        rx_valid = 1'b0;
        pulses_before = rx_pulses;
        bus_read(RX_ADDR, got);
        check_word(RX_EMPTY_WORD, got);
        repeat (2) @(negedge clk);
        check_true(rx_pulses == pulses_before, "rx_ready pulsed with no byte offered");
        finish_test();
    endtask

    task automatic test_status();
        logic [31:0] r;
        logic [31:0] got;
        logic [7:0]  exp_q[$];
        int          cyc;
        start_test("status");
        bus_read(STAT_ADDR, got);
        check_word(32'h0, got);
        rx_data  = 8'h5a;
        rx_valid = 1'b1;
        bus_read(STAT_ADDR, got);
        check_word(32'h2, got);
        rx_valid = 1'b0;
        // One byte leaves for the serializer, the rest fill the FIFO
        for (int i = 0; i < FIFO_DEPTH + 1; i++) begin
            r = next_rand();
            exp_q.push_back(r[7:0]);
            bus_write(TX_ADDR, r, 4'b0001, cyc);
        end
        bus_read(STAT_ADDR, got);
        check_word(32'h5, got);
        wait_for_bytes(FIFO_DEPTH + 1);
        repeat (2 * CLKS_PER_BIT) @(negedge clk);
        bus_read(STAT_ADDR, got);
        check_word(32'h0, got);
        check_line(exp_q);
        finish_test();
    endtask

    task automatic test_ignored();
        logic [31:0] got;
        int          hits;
        start_test("ignored");
        hits      = 0;
        mem_addr  = {8'h05, 20'h0, UART_TX_REG};
        mem_wdata = 32'h0000_00a5;
        mem_wstrb = 4'b0001;
        mem_valid = 1'b1;
        repeat (10) begin
            @(negedge clk);
            if (mem_ready === 1'b1) hits++;
        end
        check_true(hits == 0, "write to a foreign address received mem_ready");
        mem_valid = 1'b0;
        @(negedge clk);
        watch_idle_line(FRAME_CLKS + 10);
        // Reading the transmit offset completes but sends nothing
        bus_read(TX_ADDR, got);
        watch_idle_line(FRAME_CLKS + 10);
        bus_read(STAT_ADDR, got);
        check_word(32'h0, got);
        finish_test();
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        rst_n        = 1'b0;
        mem_valid    = 1'b0;
        mem_addr     = '0;
        mem_wdata    = '0;
        mem_wstrb    = '0;
        rx_valid     = 1'b0;
        rx_data      = '0;
        err_cnt      = 0;
        frame_errs   = 0;
        tests_run    = 0;
        tests_failed = 0;
        rx_pulses    = 0;
        rng_state    = 32'h34b3;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        repeat (2) @(negedge clk);
        test_single_tx();
        test_burst_tx();
        test_rx_read();
        test_status();
        test_ignored();
        $display("Summary: %0d tests, %0d failed, %0d errors",
                 tests_run, tests_failed, total_errs());
        if (total_errs() == 0 && tests_failed == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Frames for every byte sent, plus room for the bus traffic
    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Run stopped by the watchdog after %0d ns", WATCHDOG_NS);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
design/vuart_pkg.sv
design/vuart_regs.sv
design/byte_fifo.sv
design/uart_tx_serial.sv
design/vuart_top.sv
dv/vuart_chk.sv
dv/vuart_tb.sv
